//--- Bender.yml
package:
  name: cbuf_acq

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cbuf_acq_pkg.sv
      - verilog/adc_pair_collector.sv
      - verilog/cbuf_burst_sequencer.sv
      - verilog/cbuf_burst_mux.sv
      - verilog/cbuf_acq_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/cbuf_acq_tb.sv

//--- cbuf_acq_top.f
+incdir+verilog
verilog/cbuf_acq_pkg.sv
verilog/adc_pair_collector.sv
verilog/cbuf_burst_sequencer.sv
verilog/cbuf_burst_mux.sv
verilog/cbuf_acq_top.sv
tests/cbuf_acq_tb.sv

//--- tests/cbuf_acq_tb.sv
`include "cbuf_acq_settings.svh"

module cbuf_acq_tb import cbuf_acq_pkg::*; ();

    timeunit 1ns;
    timeprecision 10ps;

    localparam int RESET_CYCLES = 4;
    localparam int NUM_ROWS     = 6;

    typedef struct packed {
        logic [23:0]                   fill_num;
        logic [1:0]                    fill_type;
        logic [22:0]                   start_adr;
        logic [11:0]                   channel_tag;
        logic [`CBUF_NUM_BURSTS_W-1:0] num_bursts;
        logic [15:0]                   pre_trig;
        logic [3:0]                    alarms;      // xadc_alarms during the wfm header
        logic [3:0]                    gap;         // idle cycles after each adc_valid
        logic                          busy_start;  // second acq_start in the data phase
    } fill_row_t;

    ////////////////////////////////////////////////////////////////////////////
    // one row per fill applied back to back

    localparam fill_row_t ROWS [NUM_ROWS] = '{
        '{24'h000001, 2'd0, 23'h000100, 12'h0A5, 14'd1, 16'h0040, 4'h3, 4'd0, 1'b0},
        '{24'h000002, 2'd1, 23'h7FFFF8, 12'hFFF, 14'd0, 16'hF123, 4'h9, 4'd0, 1'b0},
        '{24'h8000FF, 2'd2, 23'h2AAAAA, 12'h5C3, 14'd5, 16'h8FFF, 4'hF, 4'd2, 1'b1},
        '{24'hFFFFFF, 2'd3, 23'h000000, 12'h001, 14'd3, 16'h0000, 4'h0, 4'd1, 1'b1},
        '{24'h123456, 2'd0, 23'h155555, 12'h800, 14'd8, 16'hABCD, 4'h6, 4'd0, 1'b0},
        '{24'h000007, 2'd1, 23'h3C3C3C, 12'h7FE, 14'd2, 16'h1000, 4'hA, 4'd3, 1'b1}
    };

    logic                          clk;
    logic                          arst_n;
    logic [`CBUF_PAIR_W-1:0]       adc_pair;
    logic                          adc_valid;
    logic                          acq_start;
    logic [23:0]                   fill_num;
    logic [1:0]                    fill_type;
    logic [22:0]                   burst_start_adr;
    logic [11:0]                   channel_tag;
    logic [`CBUF_NUM_BURSTS_W-1:0] num_bursts;
    logic [15:0]                   pre_trig;
    logic [3:0]                    xadc_alarms;
    logic [`CBUF_WORD_W-1:0]       fifo_dat;
    logic                          fifo_wr;
    logic                          busy;
    logic                          fill_done;

    logic [`CBUF_WORD_W-1:0] exp_q [$];             // expected FIFO words in order
    logic [`CBUF_PAIR_W-1:0] pair_q [$];            // pairs still to drive this fill
    logic [31:0]             rng         = 32'h80e5_6db4;
    int unsigned             cycle_cnt   = 0;
    int unsigned             cycle_limit = 0;
    int unsigned             start_cyc   = 0;       // cycle of the last real acq_start
    int unsigned             done_cyc    = 0;
    int unsigned             done_cnt    = 0;
    int unsigned             pair_idx    = 0;
    int unsigned             data_idx    = 0;

    cbuf_acq_top u_dut (
        .clk             (clk),
        .arst_n          (arst_n),
        .adc_pair        (adc_pair),
        .adc_valid       (adc_valid),
        .acq_start       (acq_start),
        .fill_num        (fill_num),
        .fill_type       (fill_type),
        .burst_start_adr (burst_start_adr),
        .channel_tag     (channel_tag),
        .num_bursts      (num_bursts),
        .pre_trig        (pre_trig),
        .xadc_alarms     (xadc_alarms),
        .fifo_dat        (fifo_dat),
        .fifo_wr         (fifo_wr),
        .busy            (busy),
        .fill_done       (fill_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                      // 4 ns period
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic wrong_value(input string msg);
        stop_run($sformatf("FAIL at %0t ns: %s", $time, msg));
    endtask

    task automatic check_header(input burst_tag_t tag, input logic [`CBUF_WORD_W-1:0] got,
                                input logic [`CBUF_WORD_W-1:0] exp);
        if (got[131:128] !== tag || got !== exp) begin
            wrong_value($sformatf("%s got %h expected %h", tag.name(), got, exp));
        end
    endtask

    task automatic check_data(input burst_tag_t tag, input int unsigned idx,
                              input logic [`CBUF_WORD_W-1:0] got,
                              input logic [`CBUF_WORD_W-1:0] exp);
        if (got[131:128] !== tag || got !== exp) begin
            wrong_value($sformatf("data word %0d got %h expected %h", idx, got, exp));
        end
    endtask

    task automatic check_checksum(input burst_tag_t tag, input logic [`CBUF_WORD_W-1:0] got,
                                  input logic [`CBUF_WORD_W-1:0] exp);
        if (got[131:128] !== tag || got !== exp) begin
            wrong_value($sformatf("checksum got %h expected %h", got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // 13-bit sample with value in 12:1 and over-range in bit 0
    function automatic logic [15:0] ext_sample(input logic [12:0] s);
        int v;
        v = $signed(s[12:1]);
        return v[15:0];
    endfunction

    function automatic logic [`CBUF_PAYLOAD_W-1:0] data_payload(
        input logic [3:0][`CBUF_PAIR_W-1:0] grp);
        logic [`CBUF_PAYLOAD_W-1:0] w;
        for (int i = 0; i < 4; i++) begin
            w[32*i +: 16]    = ext_sample(grp[i][12:0]);   // low half first
            w[32*i+16 +: 16] = ext_sample(grp[i][25:13]);
        end
        return w;
    endfunction

    function automatic logic [`CBUF_PAYLOAD_W-1:0] fill_header(input fill_row_t row);
        return {`CBUF_HDR_TAG, 3'd0, 1'b1, row.channel_tag, 6'd0, row.pre_trig,
                `CBUF_FILL_TRIG_COUNT, row.start_adr, 3'd0, 9'd0, row.num_bursts, 1'b0,
                row.fill_type, row.fill_num};
    endfunction

    function automatic logic [`CBUF_PAYLOAD_W-1:0] wfm_header(input fill_row_t row);
        return {`CBUF_HDR_TAG, 11'd0, 1'b1, row.alarms, row.channel_tag, 19'd0,
                row.pre_trig[15:12], `CBUF_WFM_INDEX, row.start_adr, 3'd0,
                row.pre_trig[11:0], row.num_bursts};
    endfunction

    task automatic make_pair(output logic [`CBUF_PAIR_W-1:0] pair);
        rng = xorshift(rng);
        if (pair_idx % 6 == 1) begin
            pair = {13'h1001, 13'h0FFF};            // 0x800 over 0x7FF with over-range set
        end else if (pair_idx % 6 == 4) begin
            pair = {13'h0FFF, 13'h1001};
        end else begin
            pair = rng[`CBUF_PAIR_W-1:0];
        end
        pair_idx++;
    endtask

    task automatic expect_fill(input fill_row_t row);
        logic [`CBUF_PAYLOAD_W-1:0]     fh;
        logic [`CBUF_PAYLOAD_W-1:0]     wh;
        logic [`CBUF_PAYLOAD_W-1:0]     dw;
        logic [`CBUF_PAYLOAD_W-1:0]     csum;
        logic [3:0][`CBUF_PAIR_W-1:0]   grp;
        fh   = fill_header(row);
        wh   = wfm_header(row);
        csum = fh ^ wh;
        exp_q.push_back({TAG_FILL_HDR, fh});
        exp_q.push_back({TAG_WFM_HDR, wh});
        for (int b = 0; b < row.num_bursts; b++) begin
            for (int i = 0; i < 4; i++) begin
                make_pair(grp[i]);
                pair_q.push_back(grp[i]);
            end
            dw   = data_payload(grp);
            csum = csum ^ dw;
            exp_q.push_back({TAG_DATA, dw});
        end
        exp_q.push_back({TAG_CHECKSUM, csum});
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // cycle count, timeout and output monitor

    always @(posedge clk) begin
        if (cycle_cnt >= cycle_limit) begin
            stop_run($sformatf("timeout, the fills did not finish in %0d cycles",
                               cycle_limit));
        end else begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    always @(negedge clk) begin                     // outputs settled since the rising edge
        logic [`CBUF_WORD_W-1:0] exp;
        burst_tag_t              tag;
        if (arst_n) begin
            if (fill_done) begin
                done_cnt++;
                done_cyc = cycle_cnt;
            end
            if (fifo_wr && exp_q.size() == 0) begin
                stop_run("FIFO write seen with no word left to expect");
            end else if (fifo_wr) begin
                exp = exp_q.pop_front();
                tag = burst_tag_t'(exp[131:128]);
                case (tag)
                    TAG_FILL_HDR: begin
                        if (cycle_cnt != start_cyc + 2) begin
                            wrong_value("fill header not two cycles after acq_start");
                        end else if (!busy) begin
                            wrong_value("busy low while the fill header is written");
                        end else begin
                            check_header(tag, fifo_dat, exp);
                        end
                    end
                    TAG_WFM_HDR: check_header(tag, fifo_dat, exp);
                    TAG_DATA: begin
                        check_data(tag, data_idx, fifo_dat, exp);
                        data_idx++;
                    end
                    default: begin
                        if (busy || cycle_cnt != done_cyc + 1) begin
                            wrong_value("checksum write not right after fill_done");
                        end else begin
                            check_checksum(tag, fifo_dat, exp);
                        end
                    end
                endcase
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    initial begin
        fill_row_t row;
        int        nvalid;
        int        ncyc;
        arst_n          = 1'b0;
        adc_pair        = '0;
        adc_valid       = 1'b0;
        acq_start       = 1'b0;
        fill_num        = '0;
        fill_type       = '0;
        burst_start_adr = '0;
        channel_tag     = '0;
        num_bursts      = '0;
        pre_trig        = '0;
        xadc_alarms     = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            cycle_limit += ROWS[r].num_bursts * 4 * (ROWS[r].gap + 1) + 10;
        end
        cycle_limit += RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            row = ROWS[r];
            expect_fill(row);
            fill_num        = row.fill_num;          // held for the whole fill
            fill_type       = row.fill_type;
            burst_start_adr = row.start_adr;
            channel_tag     = row.channel_tag;
            num_bursts      = row.num_bursts;
            pre_trig        = row.pre_trig;
            nvalid          = row.num_bursts * 4 * (row.gap + 1);
            ncyc            = (nvalid > 4) ? nvalid : 4;
            for (int c = 0; c < ncyc; c++) begin
                // extra start on a group boundary while the sequencer is busy
                acq_start   = (c == 0) || (row.busy_start && row.num_bursts > 1 &&
                                           c == 4 * (row.gap + 1));
                adc_valid   = (c < nvalid) && (c % (row.gap + 1) == 0);
                xadc_alarms = (c == 2) ? row.alarms : ~row.alarms;  // wfm header cycle only
                if (adc_valid) begin
                    adc_pair = pair_q.pop_front();
                end
                if (c == 0) begin
                    start_cyc = cycle_cnt;
                end
                next_cycle();
            end
            acq_start = 1'b0;
            adc_valid = 1'b0;
            while (done_cnt != r + 1 || exp_q.size() != 0) begin
                next_cycle();
            end
        end
        repeat (4) next_cycle();                    // room for any stray write
        if (done_cnt == NUM_ROWS && !busy) begin
            $display("Regression passed");
            $finish;
        end else begin
            stop_run($sformatf("expected %0d fill_done pulses, saw %0d", NUM_ROWS, done_cnt));
        end
    end

endmodule

//--- verilog/adc_pair_collector.sv
`include "cbuf_acq_settings.svh"

module adc_pair_collector (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    acq_start,      // restarts the pair count
    input  logic [`CBUF_PAIR_W-1:0] adc_pair,
    input  logic                    adc_valid,
    output logic [`CBUF_PAIR_W-1:0] dat0,           // oldest pair
    output logic [`CBUF_PAIR_W-1:0] dat1,
    output logic [`CBUF_PAIR_W-1:0] dat2,
    output logic [`CBUF_PAIR_W-1:0] dat3,           // newest pair
    output logic                    burst_ready     // one cycle after the fourth pair
);

    localparam int LAST_PAIR = `CBUF_PAIRS_PER_BURST - 1;

    logic [1:0]              pair_cnt;              // slot for the next pair
    logic [`CBUF_PAIR_W-1:0] stage [0:LAST_PAIR-1]; // first three pairs of the group
    logic                    last_pair;
    logic [1:0]              wr_slot;

    // a pair arriving with acq_start becomes the first of a fresh group
    assign wr_slot   = acq_start ? 2'd0 : pair_cnt;
    assign last_pair = adc_valid && (wr_slot == 2'(LAST_PAIR));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pair_cnt    <= 2'd0;
            burst_ready <= 1'b0;
        end else begin
            burst_ready <= last_pair;
            if (adc_valid) begin
                pair_cnt <= wr_slot + 2'd1;         // wraps to zero after the fourth
            end else if (acq_start) begin
                pair_cnt <= 2'd0;
            end
        end
    end

    // staging fills while the held set is being muxed
    always_ff @(posedge clk) begin
        if (adc_valid && !last_pair) begin
            stage[wr_slot] <= adc_pair;
        end
        if (last_pair) begin                        // copy the whole group in one edge
            dat0 <= stage[0];
            dat1 <= stage[1];
            dat2 <= stage[2];
            dat3 <= adc_pair;
        end
    end

    // a burst needs four strobes so two back-to-back pulses mean a broken count
    a_ready_single: assert property (@(posedge clk) disable iff (!arst_n)
        burst_ready |=> !burst_ready);

endmodule

//--- verilog/cbuf_acq_pkg.sv
package cbuf_acq_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sequencer states

    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,             // waiting for acq_start
        ST_FILL_HDR = 3'd1,             // fill header select cycle
        ST_WFM_HDR  = 3'd2,             // waveform header select cycle
        ST_DATA     = 3'd3,             // one select per burst_ready
        ST_CHECKSUM = 3'd4              // checksum select cycle, fill ends here
    } acq_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // burst contents tag in word bits 131:128

    typedef enum logic [3:0] {
        TAG_FILL_HDR = 4'd1,
        TAG_WFM_HDR  = 4'd2,
        TAG_DATA     = 4'd3,
        TAG_CHECKSUM = 4'd4
    } burst_tag_t;

endpackage

//--- verilog/cbuf_acq_settings.svh
`ifndef CBUF_ACQ_SETTINGS_SVH
`define CBUF_ACQ_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// word and field widths

`define CBUF_WORD_W           132       // 4-bit contents tag plus payload
`define CBUF_PAYLOAD_W        128       // part of the word covered by the checksum
`define CBUF_PAIR_W           26        // two 13-bit samples, over-range bit in each LSB
`define CBUF_PAIRS_PER_BURST  4         // pairs packed into one data burst
`define CBUF_NUM_BURSTS_W     14        // bursts-per-fill count

////////////////////////////////////////////////////////////////////////////
// fixed header constants

// payload bits 127:126 of any header, sign-extended data only shows 00 or 11 here
`define CBUF_HDR_TAG          2'b01
`define CBUF_FILL_TRIG_COUNT  12'd1     // final waveform count, always one in cbuf mode
`define CBUF_WFM_INDEX        23'd1     // waveform index, always one in cbuf mode

`endif

//--- verilog/cbuf_acq_top.sv
`include "cbuf_acq_settings.svh"

module cbuf_acq_top import cbuf_acq_pkg::*; (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [`CBUF_PAIR_W-1:0]       adc_pair,
    input  logic                          adc_valid,
    input  logic                          acq_start,
    input  logic [23:0]                   fill_num,
    input  logic [1:0]                    fill_type,
    input  logic [22:0]                   burst_start_adr,
    input  logic [11:0]                   channel_tag,
    input  logic [`CBUF_NUM_BURSTS_W-1:0] num_bursts,
    input  logic [15:0]                   pre_trig,
    input  logic [3:0]                    xadc_alarms,
    output logic [`CBUF_WORD_W-1:0]       fifo_dat,
    output logic                          fifo_wr,
    output logic                          busy,
    output logic                          fill_done
);

    logic [`CBUF_PAIR_W-1:0] dat0;
    logic [`CBUF_PAIR_W-1:0] dat1;
    logic [`CBUF_PAIR_W-1:0] dat2;
    logic [`CBUF_PAIR_W-1:0] dat3;
    logic                    burst_ready;
    logic                    select_fill_hdr;
    logic                    select_wfm_hdr;
    logic                    select_dat;
    logic                    select_checksum;
    acq_state_t              state;

    adc_pair_collector u_collector (
        .clk         (clk),
        .arst_n      (arst_n),
        .acq_start   (acq_start),
        .adc_pair    (adc_pair),
        .adc_valid   (adc_valid),
        .dat0        (dat0),
        .dat1        (dat1),
        .dat2        (dat2),
        .dat3        (dat3),
        .burst_ready (burst_ready)
    );

    cbuf_burst_sequencer u_sequencer (
        .clk             (clk),
        .arst_n          (arst_n),
        .acq_start       (acq_start),
        .burst_ready     (burst_ready),
        .num_bursts      (num_bursts),
        .select_fill_hdr (select_fill_hdr),
        .select_wfm_hdr  (select_wfm_hdr),
        .select_dat      (select_dat),
        .select_checksum (select_checksum),
        .state           (state),
        .busy            (busy),
        .fill_done       (fill_done)
    );

    cbuf_burst_mux u_mux (
        .clk             (clk),
        .arst_n          (arst_n),
        .dat0            (dat0),
        .dat1            (dat1),
        .dat2            (dat2),
        .dat3            (dat3),
        .channel_tag     (channel_tag),
        .fill_type       (fill_type),
        .burst_start_adr (burst_start_adr),
        .fill_num        (fill_num),
        .xadc_alarms     (xadc_alarms),
        .num_bursts      (num_bursts),
        .pre_trig        (pre_trig),
        .select_fill_hdr (select_fill_hdr),
        .select_wfm_hdr  (select_wfm_hdr),
        .select_dat      (select_dat),
        .select_checksum (select_checksum),
        .state           (state),
        .fifo_dat        (fifo_dat),
        .fifo_wr         (fifo_wr)
    );

endmodule

//--- verilog/cbuf_burst_mux.sv
`include "cbuf_acq_settings.svh"

module cbuf_burst_mux import cbuf_acq_pkg::*; (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [`CBUF_PAIR_W-1:0]       dat0,            // oldest pair
    input  logic [`CBUF_PAIR_W-1:0]       dat1,
    input  logic [`CBUF_PAIR_W-1:0]       dat2,
    input  logic [`CBUF_PAIR_W-1:0]       dat3,
    input  logic [11:0]                   channel_tag,
    input  logic [1:0]                    fill_type,
    input  logic [22:0]                   burst_start_adr, // DDR3 burst address
    input  logic [23:0]                   fill_num,
    input  logic [3:0]                    xadc_alarms,
    input  logic [`CBUF_NUM_BURSTS_W-1:0] num_bursts,
    input  logic [15:0]                   pre_trig,        // pre-trigger ADC pairs
    input  logic                          select_fill_hdr,
    input  logic                          select_wfm_hdr,
    input  logic                          select_dat,
    input  logic                          select_checksum,
    input  acq_state_t                    state,           // only checked, never decoded
    output logic [`CBUF_WORD_W-1:0]       fifo_dat,
    output logic                          fifo_wr
);

    logic [`CBUF_PAYLOAD_W-1:0] fill_hdr;
    logic [`CBUF_PAYLOAD_W-1:0] wfm_hdr;
    logic [`CBUF_PAYLOAD_W-1:0] data;
    logic [`CBUF_PAYLOAD_W-1:0] checksum;
    logic [3:0]                 alarms_q;                  // last alarms put in a header
    logic [3:0]                 alarms_hdr;
    logic [25:0]                start_adr;

    assign start_adr = {burst_start_adr, 3'd0};            // 3 LSBs always zero

    ////////////////////////////////////////////////////////////////////////////
    // cbuf fill header

    assign fill_hdr[23:0]    = fill_num;
    assign fill_hdr[25:24]   = fill_type;
    assign fill_hdr[26]      = 1'b0;                       // sync-style format
    assign fill_hdr[40:27]   = num_bursts;
    assign fill_hdr[49:41]   = 9'd0;                       // sync burst count, unused here
    assign fill_hdr[75:50]   = start_adr;
    assign fill_hdr[87:76]   = `CBUF_FILL_TRIG_COUNT;
    assign fill_hdr[103:88]  = pre_trig;
    assign fill_hdr[109:104] = 6'd0;
    assign fill_hdr[121:110] = channel_tag;
    assign fill_hdr[122]     = 1'b1;                       // cbuf flag
    assign fill_hdr[125:123] = 3'd0;
    assign fill_hdr[127:126] = `CBUF_HDR_TAG;

    ////////////////////////////////////////////////////////////////////////////
    // cbuf waveform header

    // live alarms in the select cycle so word and checksum see the same bits
    assign alarms_hdr = select_wfm_hdr ? xadc_alarms : alarms_q;

    assign wfm_hdr[13:0]     = num_bursts;
    assign wfm_hdr[25:14]    = pre_trig[11:0];             // pre-trigger LSBs
    assign wfm_hdr[51:26]    = start_adr;
    assign wfm_hdr[74:52]    = `CBUF_WFM_INDEX;
    assign wfm_hdr[78:75]    = pre_trig[15:12];            // pre-trigger MSBs
    assign wfm_hdr[97:79]    = 19'd0;
    assign wfm_hdr[109:98]   = channel_tag;
    assign wfm_hdr[113:110]  = alarms_hdr;
    assign wfm_hdr[114]      = 1'b1;                       // cbuf flag
    assign wfm_hdr[125:115]  = 11'd0;
    assign wfm_hdr[127:126]  = `CBUF_HDR_TAG;

    ////////////////////////////////////////////////////////////////////////////
    // data, eight 16-bit samples oldest in the low word

    // drop over-range bits, sign of each 12-bit value fills the top nibble
    function automatic logic [31:0] pair_words(input logic [`CBUF_PAIR_W-1:0] pair);
        return {{4{pair[25]}}, pair[25:14], {4{pair[12]}}, pair[12:1]};
    endfunction

    assign data = {pair_words(dat3), pair_words(dat2), pair_words(dat1), pair_words(dat0)};

    ////////////////////////////////////////////////////////////////////////////
    // running checksum and output register

    always_ff @(posedge clk) begin
        if (select_fill_hdr) begin
            checksum <= fill_hdr;                          // new fill starts the sum
        end else if (select_wfm_hdr) begin
            checksum <= checksum ^ wfm_hdr;
            alarms_q <= xadc_alarms;
        end else if (select_dat) begin
            checksum <= checksum ^ data;
        end
    end

    always_ff @(posedge clk) begin
        if (select_fill_hdr) begin
            fifo_dat <= {TAG_FILL_HDR, fill_hdr};
        end else if (select_wfm_hdr) begin
            fifo_dat <= {TAG_WFM_HDR, wfm_hdr};
        end else if (select_dat) begin
            fifo_dat <= {TAG_DATA, data};
        end else if (select_checksum) begin
            fifo_dat <= {TAG_CHECKSUM, checksum};          // covers selects up to last cycle
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fifo_wr <= 1'b0;
        end else begin
            fifo_wr <= select_fill_hdr | select_wfm_hdr | select_dat | select_checksum;
        end
    end

    // data outside ST_DATA would corrupt the header order of the fill
    a_dat_in_data_state: assert property (@(posedge clk) disable iff (!arst_n)
        select_dat |-> (state == ST_DATA));

endmodule

//--- verilog/cbuf_burst_sequencer.sv
`include "cbuf_acq_settings.svh"

module cbuf_burst_sequencer import cbuf_acq_pkg::*; (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         acq_start,       // ignored unless idle
    input  logic                         burst_ready,     // pulse from the collector
    input  logic [`CBUF_NUM_BURSTS_W-1:0] num_bursts,     // held stable through the fill
    output logic                         select_fill_hdr,
    output logic                         select_wfm_hdr,
    output logic                         select_dat,
    output logic                         select_checksum,
    output acq_state_t                   state,
    output logic                         busy,
    output logic                         fill_done
);

    logic [`CBUF_NUM_BURSTS_W-1:0] bursts_left;          // data selects still owed
    logic                          pending;              // burst seen during a header
    logic                          sel_dat_q;
    logic                          take_burst;

    assign take_burst = burst_ready || pending;

    ////////////////////////////////////////////////////////////////////////////
    // fill state machine

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= ST_IDLE;
            bursts_left <= '0;
            pending     <= 1'b0;
            sel_dat_q   <= 1'b0;
        end else begin
            sel_dat_q <= 1'b0;                           // single-cycle strobe
            case (state)
                ST_IDLE: begin
                    pending <= 1'b0;                     // stray bursts before a fill
                    if (acq_start) begin
                        bursts_left <= num_bursts;
                        state       <= ST_FILL_HDR;
                    end
                end
                ST_FILL_HDR: begin
                    if (burst_ready) begin
                        pending <= 1'b1;                 // hold it until ST_DATA
                    end
                    state <= ST_WFM_HDR;
                end
                ST_WFM_HDR: begin
                    pending <= 1'b0;
                    if (bursts_left == '0) begin
                        state <= ST_CHECKSUM;            // empty fill, headers only
                    end else begin
                        state <= ST_DATA;
                        if (take_burst) begin            // held or fresh burst goes first
                            sel_dat_q   <= 1'b1;
                            bursts_left <= bursts_left - 1'b1;
                        end
                    end
                end
                ST_DATA: begin
                    if (bursts_left == '0) begin
                        state <= ST_CHECKSUM;            // one cycle after the last select
                    end else if (burst_ready) begin
                        sel_dat_q   <= 1'b1;
                        bursts_left <= bursts_left - 1'b1;
                    end
                end
                ST_CHECKSUM: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // header and checksum selects decode straight from the state
    assign select_fill_hdr = (state == ST_FILL_HDR);
    assign select_wfm_hdr  = (state == ST_WFM_HDR);
    assign select_dat      = sel_dat_q;
    assign select_checksum = (state == ST_CHECKSUM);
    assign fill_done       = (state == ST_CHECKSUM); // same cycle as the checksum select
    assign busy            = (state != ST_IDLE);

    a_select_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({select_fill_hdr, select_wfm_hdr, select_dat, select_checksum}));

endmodule
